// ==== logic/kbd_matrix.sv ====
// Key matrix storage, one Wishbone read/write port and one CPU row read port
`timescale 1ns/1ns
`default_nettype none

module kbd_matrix #(
    parameter int ROW_COUNT = kbd_pkg::ROW_COUNT_DEFAULT
) (
    input  wire logic               wb_clock_i,
    input  wire logic               reset_i,

    kbd_matrix_if.store             mat,            // Wishbone side access

    input  wire kbd_pkg::row_addr_t cpu_row_i,      // Row the CPU has selected
    output kbd_pkg::data_t          cpu_row_data_o  // That row, combinational
);

    // One byte per row, a pressed key clears its bit
    kbd_pkg::data_t rows [ROW_COUNT];

    logic wb_in_range;      // Wishbone row exists
    logic cpu_in_range;     // CPU row exists
    logic wb_write;         // Store wdata at the next edge
    logic wb_oob_write;     // Write aimed past the last row

    assign wb_in_range  = (int'(mat.row) < ROW_COUNT);
    assign cpu_in_range = (int'(cpu_row_i) < ROW_COUNT);

    assign wb_write     = mat.req && mat.we && wb_in_range;
    assign wb_oob_write = mat.req && mat.we && !wb_in_range;  // Silently dropped

    // Read before write, missing rows look idle
    assign mat.rdata = wb_in_range ? rows[mat.row] : kbd_pkg::ROW_IDLE;

    // Missing rows look idle to the CPU too, so the snooper never intercepts them
    assign cpu_row_data_o = cpu_in_range ? rows[cpu_row_i] : kbd_pkg::ROW_IDLE;

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            // All keys released
            for (int i = 0; i < ROW_COUNT; i++) begin
                rows[i] <= kbd_pkg::ROW_IDLE;
            end
        end else if (wb_write) begin
            rows[mat.row] <= mat.wdata;
        end
    end

    // A write past the last row must not disturb what the CPU side sees
    a_no_oob_write : assert property (
        @(posedge wb_clock_i) disable iff (reset_i)
        wb_oob_write |=> (cpu_row_i != $past(cpu_row_i))
                      || (cpu_row_data_o == $past(cpu_row_data_o))
    ) else $error("Out of range row write changed the matrix");

endmodule

`default_nettype wire

// ==== logic/kbd_matrix_if.sv ====
// Matrix access link between the Wishbone port and the key matrix storage
`timescale 1ns/1ns
`default_nettype none

interface kbd_matrix_if;

    logic              req;     // Access this cycle
    logic              we;      // Write when high, read otherwise
    kbd_pkg::row_addr_t row;    // Row being accessed
    kbd_pkg::data_t    wdata;   // Byte to store, lands at the next edge
    kbd_pkg::data_t    rdata;   // Current row value, valid while req is high

    // Wishbone side issues the access
    modport requester (
        output req,
        output we,
        output row,
        output wdata,
        input  rdata
    );

    // Matrix side serves it
    modport store (
        input  req,
        input  we,
        input  row,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== logic/kbd_pia_snoop.sv ====
// CPU bus snooper that tracks the PIA 1 row select and answers port B reads
`timescale 1ns/1ns
`default_nettype none

module kbd_pia_snoop (
    input  wire logic               wb_clock_i,
    input  wire logic               reset_i,

    input  wire kbd_pkg::pia_rs_t   pia1_rs_i,          // PIA register select
    input  wire logic               pia1_cs_i,          // PIA chip select from the decoder
    input  wire logic               cpu_valid_strobe_i, // CPU bus cycle is valid this edge
    input  wire logic               cpu_we_i,           // CPU write when high
    input  wire kbd_pkg::data_t     cpu_data_i,

    input  wire kbd_pkg::data_t     row_data_i,         // Byte of the selected row
    output kbd_pkg::row_addr_t      row_o,              // Selected row, to the matrix

    output kbd_pkg::data_t          cpu_data_o,         // Row byte while intercepting
    output logic                    cpu_data_oe_o       // CPU data bus is driven by us
);

    localparam int RW = kbd_pkg::ROW_ADDR_WIDTH;

    kbd_pkg::row_addr_t selected_row;
    logic writing_port_a;       // CPU picks the next row to scan
    logic reading_port_b;       // CPU samples the columns of that row
    logic row_has_key;          // At least one key down in the selected row

    assign writing_port_a =  cpu_we_i && pia1_cs_i && (pia1_rs_i == kbd_pkg::PIA_PORTA);
    assign reading_port_b = !cpu_we_i && pia1_cs_i && (pia1_rs_i == kbd_pkg::PIA_PORTB);

    assign row_has_key = (row_data_i != kbd_pkg::ROW_IDLE);

    assign row_o = selected_row;

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            selected_row  <= '0;
            cpu_data_o    <= '0;
            cpu_data_oe_o <= 1'b0;
        end else if (cpu_valid_strobe_i) begin
            // Drop the bus unless this cycle is another intercept
            cpu_data_oe_o <= 1'b0;

            if (writing_port_a) begin
                selected_row <= cpu_data_i[RW-1:0];   // Upper bits go to the real PIA only
            end

            // Uses the row selected before this edge
            if (reading_port_b && row_has_key) begin
                cpu_data_o    <= row_data_i;
                cpu_data_oe_o <= 1'b1;
            end
        end
    end

    // Output enable only moves on a valid CPU cycle
    a_oe_rise_on_strobe : assert property (
        @(posedge wb_clock_i) disable iff (reset_i)
        $rose(cpu_data_oe_o) |-> $past(cpu_valid_strobe_i)
    ) else $error("cpu_data_oe_o rose without a valid strobe");

endmodule

`default_nettype wire

// ==== logic/kbd_pkg.sv ====
// Keyboard bridge shared widths, vector types, PIA register numbers and defaults
`default_nettype none

package kbd_pkg;

    // Bus widths
    localparam int DATA_WIDTH     = 8;      // Wishbone and CPU data, one byte
    localparam int WB_ADDR_WIDTH  = 17;     // Wishbone byte address
    localparam int ROW_ADDR_WIDTH = 4;      // Enough for up to 16 matrix rows
    localparam int PIA_RS_WIDTH   = 2;      // PIA register select, cpu_addr[1:0]

    // Vector types for the widths that carry a meaning
    typedef logic [DATA_WIDTH-1:0]     data_t;     // Matrix row, bus or CPU byte
    typedef logic [WB_ADDR_WIDTH-1:0]  wb_addr_t;  // Wishbone address
    typedef logic [ROW_ADDR_WIDTH-1:0] row_addr_t; // Matrix row number
    typedef logic [PIA_RS_WIDTH-1:0]   pia_rs_t;   // PIA register select

    // PIA 1 registers used by the keyboard scan
    localparam pia_rs_t PIA_PORTA = 2'd0;   // Row select, written by the CPU
    localparam pia_rs_t PIA_PORTB = 2'd2;   // Column state, read by the CPU

    // PET matrix is 10 rows of 8 columns
    localparam int ROW_COUNT_DEFAULT = 10;

    // Base of the keyboard window on the Wishbone bus
    // Low ROW_ADDR_WIDTH bits must stay zero, they carry the row number
    localparam wb_addr_t WB_BASE_DEFAULT = 17'h0E800;

    // A released key reads as 1, so an untouched row is all ones
    localparam data_t ROW_IDLE = 8'hFF;

endpackage

`default_nettype wire

// ==== logic/kbd_top.sv ====
// Keyboard bridge top level, Wishbone matrix writer plus PIA 1 scan snooper
`timescale 1ns/1ns
`default_nettype none

module kbd_top #(
    parameter int                ROW_COUNT = kbd_pkg::ROW_COUNT_DEFAULT,
    parameter kbd_pkg::wb_addr_t WB_BASE   = kbd_pkg::WB_BASE_DEFAULT
) (
    // Wishbone B4 pipelined peripheral
    input  wire logic              wb_clock_i,
    input  wire logic              reset_i,
    input  wire kbd_pkg::wb_addr_t wb_addr_i,
    input  wire kbd_pkg::data_t    wb_data_i,
    output kbd_pkg::data_t         wb_data_o,
    input  wire logic              wb_we_i,
    input  wire logic              wb_cycle_i,
    input  wire logic              wb_strobe_i,
    output logic                   wb_stall_o,
    output logic                   wb_ack_o,

    // Snooped 6502 bus at PIA 1
    input  wire kbd_pkg::pia_rs_t  pia1_rs_i,           // cpu_addr[1:0]
    input  wire logic              pia1_cs_i,           // From the address decoder
    input  wire logic              cpu_valid_strobe_i,
    input  wire kbd_pkg::data_t    cpu_data_i,
    output kbd_pkg::data_t         cpu_data_o,
    output logic                   cpu_data_oe_o,       // High while a port B read is answered
    input  wire logic              cpu_we_i
);

    kbd_matrix_if mat_if ();                // Wishbone port to matrix

    kbd_pkg::row_addr_t cpu_row;            // Row latched from port A
    kbd_pkg::data_t     cpu_row_data;       // Its current byte

    kbd_wb_port #(
        .WB_BASE(WB_BASE)
    ) u_wb_port (
        .wb_clock_i (wb_clock_i),
        .reset_i    (reset_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i),
        .wb_data_o  (wb_data_o),
        .wb_we_i    (wb_we_i),
        .wb_cycle_i (wb_cycle_i),
        .wb_strobe_i(wb_strobe_i),
        .wb_stall_o (wb_stall_o),
        .wb_ack_o   (wb_ack_o),
        .mat        (mat_if.requester)
    );

    kbd_matrix #(
        .ROW_COUNT(ROW_COUNT)
    ) u_matrix (
        .wb_clock_i    (wb_clock_i),
        .reset_i       (reset_i),
        .mat           (mat_if.store),
        .cpu_row_i     (cpu_row),
        .cpu_row_data_o(cpu_row_data)
    );

    kbd_pia_snoop u_pia_snoop (
        .wb_clock_i        (wb_clock_i),
        .reset_i           (reset_i),
        .pia1_rs_i         (pia1_rs_i),
        .pia1_cs_i         (pia1_cs_i),
        .cpu_valid_strobe_i(cpu_valid_strobe_i),
        .cpu_we_i          (cpu_we_i),
        .cpu_data_i        (cpu_data_i),
        .row_data_i        (cpu_row_data),
        .row_o             (cpu_row),
        .cpu_data_o        (cpu_data_o),
        .cpu_data_oe_o     (cpu_data_oe_o)
    );

endmodule

`default_nettype wire

// ==== logic/kbd_wb_port.sv ====
// Wishbone B4 pipelined peripheral that maps the key matrix into a 16 byte window
`timescale 1ns/1ns
`default_nettype none

module kbd_wb_port #(
    parameter kbd_pkg::wb_addr_t WB_BASE = kbd_pkg::WB_BASE_DEFAULT
) (
    input  wire logic              wb_clock_i,
    input  wire logic              reset_i,
    input  wire kbd_pkg::wb_addr_t wb_addr_i,
    input  wire kbd_pkg::data_t    wb_data_i,
    output kbd_pkg::data_t         wb_data_o,
    input  wire logic              wb_we_i,
    input  wire logic              wb_cycle_i,
    input  wire logic              wb_strobe_i,
    output logic                   wb_stall_o,
    output logic                   wb_ack_o,

    kbd_matrix_if.requester        mat          // Access path into the matrix
);

    localparam int AW = kbd_pkg::WB_ADDR_WIDTH;
    localparam int RW = kbd_pkg::ROW_ADDR_WIDTH;

    logic wb_hit;       // Address falls inside the keyboard window
    logic wb_request;   // Accepted request this cycle

    // Only the bits above the row number select the window
    assign wb_hit = (wb_addr_i[AW-1:RW] == WB_BASE[AW-1:RW]);

    assign wb_request = wb_cycle_i && wb_strobe_i && wb_hit;

    // Matrix never pushes back, every request is taken on the edge it is seen
    assign wb_stall_o = 1'b0;

    // Forward the access, low address bits are the row
    assign mat.req   = wb_request;
    assign mat.we    = wb_we_i;
    assign mat.row   = wb_addr_i[RW-1:0];
    assign mat.wdata = wb_data_i;

    // Ack and data follow the request by one edge
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            wb_ack_o  <= 1'b0;
            wb_data_o <= '0;
        end else begin
            wb_ack_o <= wb_request;     // One ack per accepted request
            if (wb_request) begin
                wb_data_o <= mat.rdata; // Old row value, also on writes
            end
        end
    end

    // Back-to-back requests each get their own ack, a gap cycle gets none
    a_ack_needs_request : assert property (
        @(posedge wb_clock_i) disable iff (reset_i)
        !wb_request |=> !wb_ack_o
    ) else $error("wb_ack_o high without an accepted request");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the keyboard bridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module kbd_tb -f sources.f -o kbd_sim \
    || { echo "Verilator build failed"; exit 1; }

# A simulator error exit counts as a failed run
./obj_dir/kbd_sim > "$LOG" 2>&1 \
    || echo "TB FAILED" >> "$LOG"

cat "$LOG"

grep -q "TB FAILED" "$LOG" \
    && { echo "Simulation failed, see $LOG"; exit 1; }

echo "Simulation passed"
exit 0

// ==== sources.f ====
logic/kbd_pkg.sv
logic/kbd_matrix_if.sv
logic/kbd_wb_port.sv
logic/kbd_matrix.sv
logic/kbd_pia_snoop.sv
logic/kbd_top.sv
tb/kbd_tb.sv

// ==== tb/kbd_tb.sv ====
// Keyboard bridge testbench, table of Wishbone and CPU bus steps checked against a row model
`timescale 1ns/1ns
`default_nettype none

module kbd_tb;

    localparam int CLK_PERIOD = 8;
    localparam int ROWS       = kbd_pkg::ROW_COUNT_DEFAULT;
    localparam int AW         = kbd_pkg::WB_ADDR_WIDTH;
    localparam int RW         = kbd_pkg::ROW_ADDR_WIDTH;

    typedef enum logic [1:0] {K_WB_WR, K_WB_RD, K_CPU_WR, K_CPU_RD} kind_t;

    // One table entry, addr holds the register select for CPU steps
    typedef struct packed {
        kind_t             kind;
        kbd_pkg::wb_addr_t addr;
        logic              cs;
        kbd_pkg::data_t    data;
        kbd_pkg::data_t    exp_data;
        logic              exp_oe;
        logic              exp_ack;
    } step_t;

    logic              wb_clock = 1'b0;
    logic              reset_i;
    kbd_pkg::wb_addr_t wb_addr;
    kbd_pkg::data_t    wb_wdata;
    kbd_pkg::data_t    wb_data_o;
    logic              wb_we;
    logic              wb_cycle;
    logic              wb_strobe;
    logic              wb_stall_o;
    logic              wb_ack_o;
    kbd_pkg::pia_rs_t  pia1_rs;
    logic              pia1_cs;
    logic              cpu_valid_strobe;
    logic              cpu_we;
    kbd_pkg::data_t    cpu_wdata;
    kbd_pkg::data_t    cpu_data_o;
    logic              cpu_data_oe_o;

    step_t              steps [$];
    kbd_pkg::data_t     model [16];     // Expected matrix contents
    kbd_pkg::row_addr_t sel_row;        // Expected snooper row
    logic               oe_model;       // Expected output enable, held between strobes
    logic               table_ready = 1'b0;
    int                 data_errors  = 0;
    int                 flag_errors  = 0;
    int                 proto_errors = 0;

    kbd_top dut (
        .wb_clock_i(wb_clock), .reset_i(reset_i),
        .wb_addr_i(wb_addr), .wb_data_i(wb_wdata), .wb_data_o(wb_data_o),
        .wb_we_i(wb_we), .wb_cycle_i(wb_cycle), .wb_strobe_i(wb_strobe),
        .wb_stall_o(wb_stall_o), .wb_ack_o(wb_ack_o),
        .pia1_rs_i(pia1_rs), .pia1_cs_i(pia1_cs), .cpu_valid_strobe_i(cpu_valid_strobe),
        .cpu_data_i(cpu_wdata), .cpu_data_o(cpu_data_o),
        .cpu_data_oe_o(cpu_data_oe_o), .cpu_we_i(cpu_we)
    );

    always #(CLK_PERIOD / 2) wb_clock = ~wb_clock;

    task automatic check_data(input string name, input kbd_pkg::data_t exp,
                              input kbd_pkg::data_t act);
        if (act !== exp) begin
            data_errors++;
            $display("[FAIL] %0t ns %s expected 8'h%02h actual 8'h%02h", $time, name, exp, act);
        end
    endtask

    task automatic check_oe(input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("[FAIL] %0t ns cpu_data_oe_o expected %b actual %b", $time, exp, act);
        end
    endtask

    task automatic check_stall(input logic act);
        if (act !== 1'b0) begin
            flag_errors++;
            $display("[FAIL] %0t ns wb_stall_o expected 0 actual %b", $time, act);
        end
    endtask

    function automatic kbd_pkg::data_t random_byte();
        return kbd_pkg::data_t'($urandom);
    endfunction

    function automatic kbd_pkg::wb_addr_t row_addr(input int r);
        return kbd_pkg::WB_BASE_DEFAULT | kbd_pkg::wb_addr_t'(r);
    endfunction

    // Window is the base address with the row bits masked off
    function automatic logic in_window(input kbd_pkg::wb_addr_t addr);
        kbd_pkg::wb_addr_t row_mask;
        row_mask = kbd_pkg::wb_addr_t'((1 << RW) - 1);
        return (addr & ~row_mask) == kbd_pkg::WB_BASE_DEFAULT;
    endfunction

    // Rows past the last are never written in the model, so they stay idle
    function automatic kbd_pkg::data_t model_row(input kbd_pkg::row_addr_t row);
        return model[row];
    endfunction

    // Wishbone step, expects the old row value back on reads and writes
    task automatic add_wb(input kind_t kind, input kbd_pkg::wb_addr_t addr,
                          input kbd_pkg::data_t data);
        step_t st;
        kbd_pkg::row_addr_t row;
        row = addr[RW-1:0];
        st.kind     = kind;
        st.addr     = addr;
        st.cs       = 1'b1;
        st.data     = data;
        st.exp_ack  = in_window(addr);
        st.exp_data = model_row(row);
        st.exp_oe   = oe_model;     // No strobe, so the intercept state holds
        if (kind == K_WB_WR && st.exp_ack && int'(row) < ROWS) begin
            model[row] = data;  // Out of range writes are dropped
        end
        steps.push_back(st);
    endtask

    // CPU step, intercept only on a chip selected port B read of a pressed row
    task automatic add_cpu(input logic we, input logic cs, input kbd_pkg::pia_rs_t rs,
                           input kbd_pkg::data_t data);
        step_t st;
        st.kind     = we ? K_CPU_WR : K_CPU_RD;
        st.addr     = kbd_pkg::wb_addr_t'(rs);
        st.cs       = cs;
        st.data     = data;
        st.exp_ack  = 1'b0;
        st.exp_data = model_row(sel_row);      // Row selected before this edge
        st.exp_oe   = !we && cs && (rs == kbd_pkg::PIA_PORTB)
                      && (model_row(sel_row) != kbd_pkg::ROW_IDLE);
        oe_model    = st.exp_oe;
        if (we && cs && rs == kbd_pkg::PIA_PORTA) begin
            sel_row = data[RW-1:0];
        end
        steps.push_back(st);
    endtask

    task automatic build_table();
        kbd_pkg::data_t nv;
        for (int i = 0; i < 16; i++) model[i] = kbd_pkg::ROW_IDLE;
        sel_row  = '0;
        oe_model = 1'b0;
        for (int r = 0; r < ROWS; r++) add_wb(K_WB_RD, row_addr(r), 8'h00);  // Reset state
        for (int r = 0; r < ROWS; r++) begin
            add_wb(K_WB_WR, row_addr(r), random_byte());
            add_wb(K_WB_RD, row_addr(r), 8'h00);
        end
        add_wb(K_WB_WR, row_addr(5), random_byte());       // Old value is now random
        add_wb(K_WB_RD, row_addr(5), 8'h00);
        add_wb(K_WB_RD, kbd_pkg::WB_BASE_DEFAULT ^ 17'h00100, 8'h00);   // Outside window
        add_wb(K_WB_WR, kbd_pkg::WB_BASE_DEFAULT ^ 17'h10003, random_byte());
        add_wb(K_WB_RD, row_addr(12), 8'h00);              // Beyond the last row
        add_wb(K_WB_WR, row_addr(12), 8'h00);
        for (int r = 0; r < ROWS; r++) add_wb(K_WB_RD, row_addr(r), 8'h00);
        // Intercept on row 3, upper nibble of the select is ignored
        add_wb(K_WB_WR, row_addr(3), random_byte() & 8'h7F);
        add_cpu(1'b1, 1'b1, kbd_pkg::PIA_PORTA, (random_byte() & 8'hF0) | 8'h03);
        add_cpu(1'b0, 1'b1, kbd_pkg::PIA_PORTB, 8'h00);
        add_cpu(1'b0, 1'b0, kbd_pkg::PIA_PORTB, 8'h00);    // Chip select low
        add_cpu(1'b0, 1'b1, kbd_pkg::PIA_PORTB, 8'h00);
        add_cpu(1'b0, 1'b1, kbd_pkg::PIA_PORTA, 8'h00);    // Port A read
        add_cpu(1'b1, 1'b1, kbd_pkg::PIA_PORTB, random_byte());  // Port B write
        add_wb(K_WB_WR, row_addr(7), kbd_pkg::ROW_IDLE);
        add_cpu(1'b1, 1'b1, kbd_pkg::PIA_PORTA, 8'h07);
        add_cpu(1'b0, 1'b1, kbd_pkg::PIA_PORTB, 8'h00);    // Idle row
        add_cpu(1'b1, 1'b1, kbd_pkg::PIA_PORTA, 8'h0C);
        add_cpu(1'b0, 1'b1, kbd_pkg::PIA_PORTB, 8'h00);    // Missing row
        // Live update of the selected row
        add_cpu(1'b1, 1'b1, kbd_pkg::PIA_PORTA, 8'h03);
        add_cpu(1'b0, 1'b1, kbd_pkg::PIA_PORTB, 8'h00);
        nv = random_byte() & 8'hBF;
        if (nv == model[3]) nv = nv ^ 8'h01;
        add_wb(K_WB_WR, row_addr(3), nv);
        add_cpu(1'b0, 1'b1, kbd_pkg::PIA_PORTB, 8'h00);
    endtask

    // One request cycle, then up to 4 cycles for the ack; starts and ends on a falling edge
    task automatic wb_access(input logic we, input kbd_pkg::wb_addr_t addr,
                             input kbd_pkg::data_t data, output logic acked,
                             output kbd_pkg::data_t rdata, output int waits);
        int waited;
        waited    = 0;
        wb_cycle  = 1'b1;
        wb_strobe = 1'b1;
        wb_we     = we;
        wb_addr   = addr;
        wb_wdata  = data;
        check_stall(wb_stall_o);
        @(posedge wb_clock);
        @(negedge wb_clock);
        wb_cycle  = 1'b0;
        wb_strobe = 1'b0;
        wb_we     = 1'b0;
        check_stall(wb_stall_o);
        while (!wb_ack_o && waited < 4) begin
            @(posedge wb_clock);
            @(negedge wb_clock);
            waited++;
        end
        acked = wb_ack_o;
        rdata = wb_data_o;
        waits = waited;     // Extra cycles beyond the first edge
    endtask

    // Single valid strobe, outputs are sampled one edge later
    task automatic cpu_access(input logic we, input logic cs, input kbd_pkg::pia_rs_t rs,
                              input kbd_pkg::data_t data);
        cpu_valid_strobe = 1'b1;
        cpu_we           = we;
        pia1_cs          = cs;
        pia1_rs          = rs;
        cpu_wdata        = data;
        @(posedge wb_clock);
        @(negedge wb_clock);
        cpu_valid_strobe = 1'b0;
        cpu_we           = 1'b0;
        pia1_cs          = 1'b0;
    endtask

    initial begin
        step_t          st;
        logic           acked;
        kbd_pkg::data_t rdata;
        int             waits;
        reset_i = 1'b1;
        wb_addr = '0;
        wb_wdata = '0;
        wb_we = 1'b0;
        wb_cycle = 1'b0;
        wb_strobe = 1'b0;
        pia1_rs = '0;
        pia1_cs = 1'b0;
        cpu_valid_strobe = 1'b0;
        cpu_we = 1'b0;
        cpu_wdata = '0;
        void'($urandom(99));
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge wb_clock);
        @(negedge wb_clock);
        reset_i = 1'b0;
        check_oe(1'b0, cpu_data_oe_o);                      // Reset values
        check_data("wb_data_o", 8'h00, wb_data_o);
        check_data("cpu_data_o", 8'h00, cpu_data_o);
        if (wb_ack_o !== 1'b0) begin
            flag_errors++;
            $display("[FAIL] %0t ns wb_ack_o expected 0 actual %b", $time, wb_ack_o);
        end
        for (int s = 0; s < steps.size(); s++) begin
            st = steps[s];
            if (st.kind == K_WB_WR || st.kind == K_WB_RD) begin
                wb_access(st.kind == K_WB_WR, st.addr, st.data, acked, rdata, waits);
                if (acked && !st.exp_ack) begin
                    proto_errors++;
                    $display("%0t ns: request to 0x%05h outside the window was acknowledged",
                             $time, st.addr);
                end else if (!acked && st.exp_ack) begin
                    proto_errors++;
                    $display("%0t ns: no ack within 4 cycles for 0x%05h", $time, st.addr);
                end else if (acked) begin
                    if (waits != 0) begin
                        proto_errors++;
                        $display("%0t ns: ack for 0x%05h came %0d cycles late",
                                 $time, st.addr, waits);
                    end
                    check_data("wb_data_o", st.exp_data, rdata);
                end
                check_oe(st.exp_oe, cpu_data_oe_o);         // Holds until the next strobe
            end else begin
                cpu_access(st.kind == K_CPU_WR, st.cs, kbd_pkg::pia_rs_t'(st.addr), st.data);
                check_oe(st.exp_oe, cpu_data_oe_o);
                if (st.exp_oe) check_data("cpu_data_o", st.exp_data, cpu_data_o);
            end
        end
        $display("Errors: data %0d, flag %0d, protocol %0d",
                 data_errors, flag_errors, proto_errors);
        if (data_errors + flag_errors + proto_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        repeat (steps.size() * 10 + 100) @(posedge wb_clock);
        $display("Watchdog expired before the table finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
